/* Bender.yml */
package:
  name: memAlign

sources:
  # package first, then leaf modules, then the top level
  - files:
      - common/alignPkg.sv
      - translation/tlbTable.sv
      - translation/pageTranslator.sv
      - design/accessSplitter.sv
      - design/translationMerger.sv
      - design/memAlignTop.sv

  - target: test
    include_dirs:
      - verification
    files:
      - verification/tbMemAlign.sv

/* common/alignPkg.sv */
`default_nettype none

package alignPkg;

    // cache line geometry
    localparam int LineBytes = 16;
    localparam int OffsetBits = 4;

    // virtual and physical page layout
    localparam int PageOffsetBits = 12;
    localparam int VpnBits = 20;
    localparam int FrameBits = 3;
    localparam int PhysAddrBits = FrameBits + PageOffsetBits;

    // shared tlb and split lanes
    localparam int TlbEntries = 8;
    localparam int TlbIndexBits = $clog2(TlbEntries);
    localparam int NumHalves = 2;

    typedef enum logic [1:0] {
        opRead,
        opWrite,
        opSwap
    } accessOp_e;

    // encoding n means 2^n bytes
    typedef enum logic [1:0] {
        size1,
        size2,
        size4,
        size8
    } accessSize_e;

    typedef struct packed {
        logic                     valid;
        logic [31:0]              vAddr;
        accessOp_e                op;
        accessSize_e              size;
        logic                     lineFill;
        logic [LineBytes*8-1:0]   data;
    } accessReq_t;

    // one line-sized piece of an access
    typedef struct packed {
        logic                     valid;
        logic [31:0]              vAddr;
        logic [LineBytes-1:0]     byteMask;
        logic [LineBytes*8-1:0]   data;
        accessOp_e                op;
    } lineReq_t;

    typedef struct packed {
        logic                     valid;
        logic [VpnBits-1:0]       vpn;
        logic [FrameBits-1:0]     frame;
        logic                     writable;
        logic                     cacheDisable;
    } tlbEntry_t;

    typedef struct packed {
        logic                     we;
        logic [TlbIndexBits-1:0]  index;
        tlbEntry_t                entry;
    } tlbFill_t;

    typedef struct packed {
        logic                     valid;
        logic [PhysAddrBits-1:0]  pAddr;
        logic [LineBytes-1:0]     byteMask;
        logic [LineBytes*8-1:0]   data;
        accessOp_e                op;
        logic                     miss;
        logic                     fault;
        logic                     uncached;
    } physReq_t;

endpackage

`default_nettype wire

/* design/accessSplitter.sv */
`timescale 1ns/10ps
`default_nettype none

module accessSplitter import alignPkg::*; (
    input  logic                          clk,
    input  logic                          reset,
    input  accessReq_t                    req,
    output lineReq_t [NumHalves-1:0]      halves
);

    logic [OffsetBits-1:0]      offset;
    logic [3:0]                 byteCount;
    logic [OffsetBits:0]        endByte;
    logic                       crosses;
    logic [LineBytes-1:0]       lowMask;
    logic [2*LineBytes-1:0]     wideMask;
    logic [2*LineBytes*8-1:0]   wideData;
    logic [31:0]                nextLineAddr;
    lineReq_t [NumHalves-1:0]   nextHalves;

    // byte position inside the line and access length
    assign offset = req.vAddr[OffsetBits-1:0];
    assign byteCount = 4'd1 << req.size;
    assign endByte = {1'b0, offset} + {1'b0, byteCount};

    // spills into the next line only for ordinary accesses
    assign crosses = !req.lineFill && (endByte > (OffsetBits + 1)'(LineBytes));

    // mask and data shifted across a double-width window
    // low half lands in line 0, upper half spills into line 1
    assign lowMask = (16'd1 << byteCount) - 16'd1;
    assign wideMask = {{LineBytes{1'b0}}, lowMask} << offset;
    assign wideData = {{LineBytes*8{1'b0}}, req.data} << {offset, 3'b000};

    assign nextLineAddr = (req.vAddr + 32'(LineBytes)) & ~32'(LineBytes - 1);

    always_comb begin
        nextHalves[0].valid = req.valid;
        nextHalves[0].vAddr = req.vAddr;
        nextHalves[0].op = req.op;
        if (req.lineFill) begin
            // line fills bypass alignment
            nextHalves[0].byteMask = '1;
            nextHalves[0].data = req.data;
        end else begin
            nextHalves[0].byteMask = wideMask[LineBytes-1:0];
            nextHalves[0].data = wideData[LineBytes*8-1:0];
        end

        nextHalves[1].valid = req.valid && crosses;
        nextHalves[1].vAddr = nextLineAddr;
        nextHalves[1].op = req.op;
        nextHalves[1].byteMask = wideMask[2*LineBytes-1:LineBytes];
        nextHalves[1].data = wideData[2*LineBytes*8-1:LineBytes*8];
    end

    // payload always loads, only the valids see reset
    always_ff @(posedge clk) begin
        halves <= nextHalves;
        if (reset) begin
            for (int i = 0; i < NumHalves; i++) begin
                halves[i].valid <= 1'b0;
            end
        end
    end

    // a spilled piece always belongs to an access that also has a first piece
    assert property (@(posedge clk) disable iff (reset)
        halves[1].valid |-> halves[0].valid);

endmodule

`default_nettype wire

/* design/memAlignTop.sv */
`timescale 1ns/10ps
`default_nettype none

module memAlignTop import alignPkg::*; (
    input  logic          clk,
    input  logic          reset,
    input  accessReq_t    req,
    input  tlbFill_t      fill,
    output physReq_t      half0,
    output physReq_t      half1,
    output logic          accessMiss,
    output logic          accessFault,
    output logic          accessUncached,
    output logic          splitNeeded
);

    lineReq_t  [NumHalves-1:0]    halves;
    tlbEntry_t [TlbEntries-1:0]   entries;
    physReq_t  [NumHalves-1:0]    lanes;

    // stage 1: offset, split, masks and shifted data
    accessSplitter splitter (
        .clk    (clk),
        .reset  (reset),
        .req    (req),
        .halves (halves)
    );

    // single tlb shared by both lanes
    tlbTable tlb (
        .clk     (clk),
        .reset   (reset),
        .fill    (fill),
        .entries (entries)
    );

    // stage 2: one translator per half
    for (genvar i = 0; i < NumHalves; i++) begin : lane
        pageTranslator translator (
            .clk     (clk),
            .reset   (reset),
            .lineIn  (halves[i]),
            .entries (entries),
            .physOut (lanes[i])
        );
    end

    translationMerger merger (
        .lanes          (lanes),
        .half0          (half0),
        .half1          (half1),
        .accessMiss     (accessMiss),
        .accessFault    (accessFault),
        .accessUncached (accessUncached),
        .splitNeeded    (splitNeeded)
    );

endmodule

`default_nettype wire

/* design/translationMerger.sv */
`timescale 1ns/10ps
`default_nettype none

module translationMerger import alignPkg::*; (
    input  physReq_t [NumHalves-1:0]      lanes,
    output physReq_t                      half0,
    output physReq_t                      half1,
    output logic                          accessMiss,
    output logic                          accessFault,
    output logic                          accessUncached,
    output logic                          splitNeeded
);

    logic                       squash;
    physReq_t [NumHalves-1:0]   merged;

    // flags of unused lanes are ignored
    always_comb begin
        accessMiss = 1'b0;
        accessFault = 1'b0;
        accessUncached = 1'b0;
        for (int i = 0; i < NumHalves; i++) begin
            accessMiss = accessMiss || (lanes[i].valid && lanes[i].miss);
            accessFault = accessFault || (lanes[i].valid && lanes[i].fault);
            accessUncached = accessUncached || (lanes[i].valid && lanes[i].uncached);
        end
    end

    // one bad half kills the whole access
    assign squash = accessMiss || accessFault;

    always_comb begin
        for (int i = 0; i < NumHalves; i++) begin
            merged[i] = lanes[i];
            merged[i].valid = lanes[i].valid && !squash;
        end
    end

    assign half0 = merged[0];
    assign half1 = merged[1];

    // reflects the split even when the access is squashed
    assign splitNeeded = lanes[1].valid;

endmodule

`default_nettype wire

/* src.f */
+incdir+verification
common/alignPkg.sv
translation/tlbTable.sv
translation/pageTranslator.sv
design/accessSplitter.sv
design/translationMerger.sv
design/memAlignTop.sv
verification/tbMemAlign.sv

/* translation/pageTranslator.sv */
`timescale 1ns/10ps
`default_nettype none

module pageTranslator import alignPkg::*; (
    input  logic                          clk,
    input  logic                          reset,
    input  lineReq_t                      lineIn,
    input  tlbEntry_t [TlbEntries-1:0]    entries,
    output physReq_t                      physOut
);

    logic [VpnBits-1:0]     vpn;
    logic [TlbEntries-1:0]  hitVec;
    logic                   hit;
    tlbEntry_t              matched;
    logic                   needsWrite;
    physReq_t               physNext;

    assign vpn = lineIn.vAddr[31:PageOffsetBits];

    // fully associative compare against every slot
    always_comb begin
        for (int i = 0; i < TlbEntries; i++) begin
            hitVec[i] = entries[i].valid && (entries[i].vpn == vpn);
        end
    end

    // lowest matching slot wins if a page is loaded twice
    always_comb begin
        hit = 1'b0;
        matched = '0;
        for (int i = TlbEntries - 1; i >= 0; i--) begin
            if (hitVec[i]) begin
                hit = 1'b1;
                matched = entries[i];
            end
        end
    end

    assign needsWrite = (lineIn.op == opWrite) || (lineIn.op == opSwap);

    always_comb begin
        physNext.valid = lineIn.valid;
        physNext.pAddr = {matched.frame, lineIn.vAddr[PageOffsetBits-1:0]};
        physNext.byteMask = lineIn.byteMask;
        physNext.data = lineIn.data;
        physNext.op = lineIn.op;
        physNext.miss = !hit;
        physNext.fault = hit && needsWrite && !matched.writable;
        physNext.uncached = hit && matched.cacheDisable;
    end

    always_ff @(posedge clk) begin
        physOut <= physNext;
        if (reset) begin
            physOut.valid <= 1'b0;
        end
    end

    // protection is only judged on a page that translated
    assert property (@(posedge clk) disable iff (reset)
        physOut.valid |-> !(physOut.miss && physOut.fault));

endmodule

`default_nettype wire

/* translation/tlbTable.sv */
`timescale 1ns/10ps
`default_nettype none

module tlbTable import alignPkg::*; (
    input  logic                          clk,
    input  logic                          reset,
    input  tlbFill_t                      fill,
    output tlbEntry_t [TlbEntries-1:0]    entries
);

    // fill overwrites one slot; reset wins and invalidates everything
    always_ff @(posedge clk) begin
        if (fill.we) begin
            entries[fill.index] <= fill.entry;
        end
        if (reset) begin
            for (int i = 0; i < TlbEntries; i++) begin
                entries[i].valid <= 1'b0;
            end
        end
    end

    // a write strobe must point at a real slot
    assert property (@(posedge clk) disable iff (reset)
        fill.we |-> !$isunknown(fill.index));

endmodule

`default_nettype wire

/* verification/alignModel.svh */
`ifndef ALIGN_MODEL_SVH
`define ALIGN_MODEL_SVH

// expected outputs of one access, two cycles after it enters
typedef struct packed {
    physReq_t half0;
    physReq_t half1;
    logic     miss;
    logic     fault;
    logic     uncached;
    logic     split;
} expected_t;

// reference copy of the tlb, updated on the cycle a fill is driven
tlbEntry_t modelTlb [TlbEntries];

// page lookup for one half, first valid slot in index order
function automatic physReq_t translateHalf(input lineReq_t line);
    physReq_t p;
    int hitIdx;
    p = '0;
    hitIdx = -1;
    for (int i = 0; i < TlbEntries; i++) begin
        if (hitIdx < 0 && modelTlb[i].valid && modelTlb[i].vpn == line.vAddr[31:12]) begin
            hitIdx = i;
        end
    end
    p.valid = line.valid;
    p.byteMask = line.byteMask;
    p.data = line.data;
    p.op = line.op;
    p.miss = (hitIdx < 0);
    if (hitIdx >= 0) begin
        p.pAddr = {modelTlb[hitIdx].frame, line.vAddr[11:0]};
        p.fault = (line.op != opRead) && !modelTlb[hitIdx].writable;
        p.uncached = modelTlb[hitIdx].cacheDisable;
    end
    return p;
endfunction

// split, mask and byte placement, then translation and merge
function automatic expected_t predictAccess(input accessReq_t r);
    expected_t e;
    lineReq_t part [NumHalves];
    physReq_t lane [NumHalves];
    int offset;
    int count;
    e = '0;
    part[0] = '0;
    part[1] = '0;
    offset = r.vAddr[3:0];
    count = 1 << r.size;
    part[0].valid = r.valid;
    part[0].vAddr = r.vAddr;
    part[0].op = r.op;
    part[1].valid = r.valid && !r.lineFill && (offset + count > LineBytes);
    part[1].vAddr = {r.vAddr[31:4] + 28'd1, 4'h0};
    part[1].op = r.op;
    for (int b = 0; b < LineBytes; b++) begin
        if (r.lineFill) begin
            part[0].byteMask[b] = 1'b1;
            part[0].data[8*b +: 8] = r.data[8*b +: 8];
        end else begin
            part[0].byteMask[b] = (b >= offset) && (b < offset + count);
            part[1].byteMask[b] = (b < offset + count - LineBytes);
            if (b >= offset) begin
                part[0].data[8*b +: 8] = r.data[8*(b - offset) +: 8];
            end else begin
                // bytes that spilled past the end of the first line
                part[1].data[8*b +: 8] = r.data[8*(b + LineBytes - offset) +: 8];
            end
        end
    end
    for (int h = 0; h < NumHalves; h++) begin
        lane[h] = translateHalf(part[h]);
        e.miss = e.miss || (lane[h].valid && lane[h].miss);
        e.fault = e.fault || (lane[h].valid && lane[h].fault);
        e.uncached = e.uncached || (lane[h].valid && lane[h].uncached);
    end
    e.split = part[1].valid;
    e.half0 = lane[0];
    e.half1 = lane[1];
    e.half0.valid = lane[0].valid && !(e.miss || e.fault);
    e.half1.valid = lane[1].valid && !(e.miss || e.fault);
    return e;
endfunction

`endif

/* verification/tbMemAlign.sv */
`timescale 1ns/10ps
`default_nettype none

module tbMemAlign import alignPkg::*; ();

    localparam int CyclesPerTest = 200;
    localparam int NumTests = 6;
    // reset, queue priming, tlb load, then each test plus its drain
    localparam int TotalCycles = 4 + TlbEntries + NumTests * (CyclesPerTest + 2);
    localparam int TimeoutLimit = 4 * TotalCycles;

    logic        clk;
    logic        reset;
    accessReq_t  req;
    tlbFill_t    fill;
    physReq_t    half0;
    physReq_t    half1;
    logic        accessMiss;
    logic        accessFault;
    logic        accessUncached;
    logic        splitNeeded;

    int          passCount = 0;
    int          errorCount = 0;
    int          cycleCount = 0;
    int          seedValue;
    logic [19:0] lastFillVpn = '0;
    logic [19:0] bases [3] = '{20'h00400, 20'h12340, 20'h7ff00};
    accessReq_t  idleReq = '0;
    tlbFill_t    noFill = '0;

    `include "alignModel.svh"

    expected_t   expQ [$];

    memAlignTop dut (
        .clk            (clk),
        .reset          (reset),
        .req            (req),
        .fill           (fill),
        .half0          (half0),
        .half1          (half1),
        .accessMiss     (accessMiss),
        .accessFault    (accessFault),
        .accessUncached (accessUncached),
        .splitNeeded    (splitNeeded)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TimeoutLimit) begin
            $display("pipeline timed out after %0d cycles", cycleCount);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic compareField(input string name, input logic [127:0] expected,
                                input logic [127:0] actual);
        if (actual !== expected) begin
            errorCount++;
            $display("** Error at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
        end else begin
            passCount++;
        end
    endtask

    // payload only matters on a half that goes out
    task automatic compareHalf(input string name, input physReq_t exp, input physReq_t act);
        compareField({name, ".valid"}, exp.valid, act.valid);
        if (exp.valid) begin
            compareField({name, ".pAddr"}, exp.pAddr, act.pAddr);
            compareField({name, ".byteMask"}, exp.byteMask, act.byteMask);
            compareField({name, ".data"}, exp.data, act.data);
            compareField({name, ".op"}, exp.op, act.op);
            compareField({name, ".miss"}, exp.miss, act.miss);
            compareField({name, ".fault"}, exp.fault, act.fault);
            compareField({name, ".uncached"}, exp.uncached, act.uncached);
        end
    endtask

    task automatic compareOutputs(input expected_t e);
        compareHalf("half0", e.half0, half0);
        compareHalf("half1", e.half1, half1);
        compareField("accessMiss", e.miss, accessMiss);
        compareField("accessFault", e.fault, accessFault);
        compareField("accessUncached", e.uncached, accessUncached);
        compareField("splitNeeded", e.split, splitNeeded);
    endtask

    // drive on the rising edge and check the result due two cycles back
    task automatic stepCycle(input accessReq_t r, input tlbFill_t f);
        expected_t e;
        @(posedge clk);
        req <= r;
        fill <= f;
        if (f.we) begin
            modelTlb[f.index] = f.entry;
        end
        expQ.push_back(predictAccess(r));
        @(negedge clk);
        e = expQ.pop_front();
        compareOutputs(e);
    endtask

    function automatic logic [19:0] mappedVpn(input bit readOnly);
        int i;
        for (int tries = 0; tries < 64; tries++) begin
            i = $urandom % TlbEntries;
            if (modelTlb[i].valid && (!readOnly || !modelTlb[i].writable)) begin
                return modelTlb[i].vpn;
            end
        end
        return modelTlb[1].vpn;
    endfunction

    function automatic tlbFill_t randomFill();
        tlbFill_t f;
        f = '0;
        f.we = 1'b1;
        f.index = 3'($urandom);
        f.entry.valid = 1'b1;
        f.entry.vpn = bases[$urandom % 3] + 20'($urandom % 12);
        f.entry.frame = 3'($urandom);
        f.entry.writable = ($urandom % 3) != 0;
        f.entry.cacheDisable = ($urandom % 4) == 0;
        return f;
    endfunction

    function automatic accessReq_t makeRequest(input int kind);
        accessReq_t r;
        int count;
        int offset;
        logic [19:0] vpn;
        logic [11:0] pageOffset;
        r = '0;
        r.valid = 1'b1;
        r.op = accessOp_e'($urandom % 3);
        r.size = accessSize_e'($urandom % 4);
        r.data = {$urandom, $urandom, $urandom, $urandom};
        vpn = mappedVpn(1'b0);
        count = 1 << r.size;
        offset = $urandom % LineBytes;
        case (kind)
            1: offset = ($urandom % (LineBytes / count)) * count;
            2: begin
                if (r.size == size1) begin
                    r.size = size8;
                    count = 8;
                end
                offset = LineBytes - count + 1 + ($urandom % (count - 1));
            end
            3: vpn = bases[$urandom % 3] + 20'($urandom % 12);
            4: vpn = mappedVpn(1'b1);
            5: r.lineFill = 1'b1;
            default: begin
                if ($urandom % 2) begin
                    vpn = lastFillVpn;
                end
            end
        endcase
        pageOffset = {8'($urandom), 4'(offset)};
        // last line of a mapped page spilling into a page that may be unmapped
        if (kind == 3 && ($urandom % 2)) begin
            vpn = mappedVpn(1'b0);
            r.size = size8;
            pageOffset = 12'hffc;
        end
        r.vAddr = {vpn, pageOffset};
        return r;
    endfunction

    // distinct vpns, slot 1 read-only, slot 2 uncached, last two slots empty
    task automatic loadTlb();
        tlbFill_t f;
        for (int i = 0; i < TlbEntries; i++) begin
            f = '0;
            f.we = 1'b1;
            f.index = 3'(i);
            f.entry.valid = (i < TlbEntries - 2);
            f.entry.vpn = bases[i % 3] + 20'(4 * (i / 3)) + 20'($urandom % 4);
            f.entry.frame = 3'($urandom);
            f.entry.writable = (i != 1) && (($urandom % 3) != 0 || i == 0);
            f.entry.cacheDisable = (i == 2) || (i != 0 && ($urandom % 4) == 0);
            stepCycle(idleReq, f);
        end
        $display("tlb load: %0d entries written, %0d errors", TlbEntries, errorCount);
    endtask

    task automatic runTest(input int kind, input string name);
        int errorsBefore;
        int passesBefore;
        accessReq_t r;
        tlbFill_t f;
        errorsBefore = errorCount;
        passesBefore = passCount;
        for (int n = 0; n < CyclesPerTest; n++) begin
            f = '0;
            if (kind == 6 && ($urandom % 8) == 0) begin
                f = randomFill();
                lastFillVpn = f.entry.vpn;
            end
            if (($urandom % 4) == 0) begin
                r = idleReq;
            end else begin
                r = makeRequest(kind);
            end
            stepCycle(r, f);
        end
        repeat (2) stepCycle(idleReq, noFill);
        $display("test %0d %s: %0d checks passed, %0d errors", kind, name,
                 passCount - passesBefore, errorCount - errorsBefore);
    endtask

    initial begin
        seedValue = $urandom(32'h5d77);
        clk = 1'b0;
        reset = 1'b1;
        req = '0;
        fill = '0;
        for (int i = 0; i < TlbEntries; i++) begin
            modelTlb[i] = '0;
        end
        // pipeline is empty right after reset
        expQ.push_back(predictAccess(idleReq));
        expQ.push_back(predictAccess(idleReq));
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        loadTlb();
        runTest(1, "aligned accesses");
        runTest(2, "line crossing");
        runTest(3, "unmapped pages");
        runTest(4, "read-only pages");
        runTest(5, "line fills");
        runTest(6, "refill in flight");

        $display("checks passed: %0d, errors: %0d", passCount, errorCount);
        if (errorCount == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
